// ==== rtl/isa_pkg.sv ====
package isa_pkg;

	// instruction field widths
	localparam int WORD_W   = 32;
	localparam int OPCODE_W = 6;
	localparam int FUNC_W   = 6;
	localparam int REG_AW   = 5;
	localparam int SHAMT_W  = 5;
	localparam int IMM_W    = 16;
	localparam int TARGET_W = 26;
	localparam int NUM_REGS = 32;
	localparam int ALU_W    = 3;

	// primary opcodes
	localparam logic [OPCODE_W-1:0] RTYPE_OP = 6'b000000;
	localparam logic [OPCODE_W-1:0] ADDI_OP  = 6'b001000;
	localparam logic [OPCODE_W-1:0] LW_OP    = 6'b100011;
	localparam logic [OPCODE_W-1:0] SW_OP    = 6'b101011;
	localparam logic [OPCODE_W-1:0] J_OP     = 6'b000010;
	localparam logic [OPCODE_W-1:0] BEQ_OP   = 6'b000100;

	// function codes under RTYPE_OP
	localparam logic [FUNC_W-1:0] ADD_FUNC = 6'b100000;
	localparam logic [FUNC_W-1:0] SUB_FUNC = 6'b100010;
	localparam logic [FUNC_W-1:0] MUL_FUNC = 6'b011000;
	localparam logic [FUNC_W-1:0] AND_FUNC = 6'b100100;
	localparam logic [FUNC_W-1:0] OR_FUNC  = 6'b100101;

	// ALU operation select
	localparam logic [ALU_W-1:0] ALU_ADD = 3'b001;
	localparam logic [ALU_W-1:0] ALU_SUB = 3'b010;
	localparam logic [ALU_W-1:0] ALU_MUL = 3'b011;
	localparam logic [ALU_W-1:0] ALU_AND = 3'b100;
	localparam logic [ALU_W-1:0] ALU_OR  = 3'b101;

	typedef struct packed {
		logic [OPCODE_W-1:0] opcode;
		logic [REG_AW-1:0]   rs;
		logic [REG_AW-1:0]   rt;
		logic [REG_AW-1:0]   rd;
		logic [SHAMT_W-1:0]  shamt;
		logic [FUNC_W-1:0]   func;
	} r_fmt_t;

	typedef struct packed {
		logic [OPCODE_W-1:0] opcode;
		logic [REG_AW-1:0]   rs;
		logic [REG_AW-1:0]   rt;
		logic [IMM_W-1:0]    imm;
	} i_fmt_t;

	typedef struct packed {
		logic [OPCODE_W-1:0] opcode;
		logic [TARGET_W-1:0] target;
	} j_fmt_t;

	// one instruction word, three ways of reading it
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_u;

endpackage

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

	// next-PC select, msb set means redirect
	localparam int               PC_SEL_W      = 2;
	localparam logic [PC_SEL_W-1:0] PC_SEL_SEQ    = 2'b00;
	localparam logic [PC_SEL_W-1:0] PC_SEL_JUMP   = 2'b10;
	localparam logic [PC_SEL_W-1:0] PC_SEL_BRANCH = 2'b11;

	// ex bundle is { alu op(3), imm source, rd destination }
	localparam int EX_CTRL_W  = 5;
	localparam int EX_ALU_LSB = 2;
	localparam int EX_SRC_BIT = 1;
	localparam int EX_DST_BIT = 0;

	// mem bundle is { chip select, write enable }
	localparam int MEM_CTRL_W = 2;
	localparam int MEM_CS_BIT = 1;
	localparam int MEM_WE_BIT = 0;

	// wb bundle is { alu not memory, register write }
	localparam int WB_CTRL_W  = 2;
	localparam int WB_ALU_BIT = 1;
	localparam int WB_WE_BIT  = 0;

	// word-addressed program counter and data memory
	localparam int PC_W       = 8;
	localparam int DMEM_DEPTH = 256;
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

endpackage

// ==== rtl/general_control.sv ====
module general_control (
	input  logic [isa_pkg::OPCODE_W-1:0]     op_i,
	input  logic [isa_pkg::FUNC_W-1:0]       func_i,
	input  logic                             is_equal_i,
	output logic [pipe_pkg::PC_SEL_W-1:0]    pc_sel_o,
	output logic [pipe_pkg::EX_CTRL_W-1:0]   ex_ctrl_o,
	output logic [pipe_pkg::MEM_CTRL_W-1:0]  mem_ctrl_o,
	output logic [pipe_pkg::WB_CTRL_W-1:0]   wb_ctrl_o
);

	always_comb
	begin
		// anything not listed below decodes as a nop
		pc_sel_o   = pipe_pkg::PC_SEL_SEQ;
		ex_ctrl_o  = '0;
		mem_ctrl_o = '0;
		wb_ctrl_o  = '0;
		case (op_i)
			isa_pkg::RTYPE_OP:
			begin
				ex_ctrl_o = {isa_pkg::ALU_ADD, 1'b0, 1'b1};
				wb_ctrl_o = 2'b11;
				case (func_i)
					isa_pkg::ADD_FUNC: ex_ctrl_o[4:2] = isa_pkg::ALU_ADD;
					isa_pkg::SUB_FUNC: ex_ctrl_o[4:2] = isa_pkg::ALU_SUB;
					isa_pkg::MUL_FUNC: ex_ctrl_o[4:2] = isa_pkg::ALU_MUL;
					isa_pkg::AND_FUNC: ex_ctrl_o[4:2] = isa_pkg::ALU_AND;
					isa_pkg::OR_FUNC:  ex_ctrl_o[4:2] = isa_pkg::ALU_OR;
					default:
					begin
						ex_ctrl_o = '0;
						wb_ctrl_o = '0;
					end
				endcase
			end
			isa_pkg::ADDI_OP:
			begin
				ex_ctrl_o = {isa_pkg::ALU_ADD, 1'b1, 1'b0};
				wb_ctrl_o = 2'b11;
			end
			isa_pkg::LW_OP:
			begin
				ex_ctrl_o  = {isa_pkg::ALU_ADD, 1'b1, 1'b0};
				mem_ctrl_o = 2'b10;
				wb_ctrl_o  = 2'b01;
			end
			isa_pkg::SW_OP:
			begin
				ex_ctrl_o  = {isa_pkg::ALU_ADD, 1'b1, 1'b0};
				mem_ctrl_o = 2'b11;
			end
			isa_pkg::J_OP:
				pc_sel_o = pipe_pkg::PC_SEL_JUMP;
			isa_pkg::BEQ_OP:
			begin
				// compare happens in decode, so the branch resolves here
				if (is_equal_i)
					pc_sel_o = pipe_pkg::PC_SEL_BRANCH;
			end
			default:
			begin
				pc_sel_o = pipe_pkg::PC_SEL_SEQ;
			end
		endcase
	end

endmodule

// ==== rtl/reg_file.sv ====
module reg_file (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic [isa_pkg::REG_AW-1:0]  ra_i,
	input  logic [isa_pkg::REG_AW-1:0]  rb_i,
	input  logic [isa_pkg::REG_AW-1:0]  wa_i,
	input  logic [isa_pkg::WORD_W-1:0]  wd_i,
	input  logic                        we_i,
	output logic [isa_pkg::WORD_W-1:0]  rda_o,
	output logic [isa_pkg::WORD_W-1:0]  rdb_o
);

	logic [isa_pkg::WORD_W-1:0] regs [isa_pkg::NUM_REGS];

	// write-first behaviour so decode sees this cycle's write back
	function automatic logic [isa_pkg::WORD_W-1:0] read_port(input logic [isa_pkg::REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (we_i && wa_i == addr)
			return wd_i;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < isa_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we_i && wa_i != '0)
			regs[wa_i] <= wd_i;
	end

	assign rda_o = read_port(ra_i);
	assign rdb_o = read_port(rb_i);

	assert property (@(posedge clk_i) disable iff (!rst_n_i) we_i |-> !$isunknown(wa_i))
		else $error("register write with unknown address");

endmodule

// ==== rtl/fetch_unit.sv ====
module fetch_unit (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           stall_i,
	input  logic [pipe_pkg::PC_SEL_W-1:0]  pc_sel_i,
	input  logic [pipe_pkg::PC_W-1:0]      jump_target_i,
	input  logic [pipe_pkg::PC_W-1:0]      branch_target_i,
	input  logic [isa_pkg::WORD_W-1:0]     imem_data_i,
	output logic [pipe_pkg::PC_W-1:0]      imem_addr_o,
	output logic [isa_pkg::WORD_W-1:0]     ifid_instr_o,
	output logic [pipe_pkg::PC_W-1:0]      ifid_pc_plus1_o,
	output logic                           ifid_valid_o
);

	logic [pipe_pkg::PC_W-1:0] pc_q;
	logic [pipe_pkg::PC_W-1:0] pc_plus1;
	logic [pipe_pkg::PC_W-1:0] pc_next;
	logic                      redirect;

	assign imem_addr_o = pc_q;
	assign pc_plus1    = pc_q + 1'b1;
	assign redirect    = (pc_sel_i != pipe_pkg::PC_SEL_SEQ);

	always_comb
	begin
		case (pc_sel_i)
			pipe_pkg::PC_SEL_JUMP:   pc_next = jump_target_i;
			pipe_pkg::PC_SEL_BRANCH: pc_next = branch_target_i;
			default:                 pc_next = pc_plus1;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pc_q         <= '0;
			ifid_instr_o <= '0;
			ifid_valid_o <= 1'b0;
		end
		else if (!stall_i)
		begin
			pc_q <= pc_next;
			// the word behind a taken jump or branch becomes a bubble
			ifid_instr_o <= redirect ? '0 : imem_data_i;
			ifid_valid_o <= !redirect;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
			ifid_pc_plus1_o <= pc_plus1;
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i) stall_i |-> !redirect)
		else $error("redirect requested during a decode stall");

endmodule

// ==== rtl/hazard_unit.sv ====
module hazard_unit (
	input  logic [isa_pkg::REG_AW-1:0]  rs_i,
	input  logic [isa_pkg::REG_AW-1:0]  rt_i,
	input  logic                        uses_rt_i,
	input  logic [isa_pkg::REG_AW-1:0]  ex_dst_i,
	input  logic                        ex_we_i,
	input  logic [isa_pkg::REG_AW-1:0]  mem_dst_i,
	input  logic                        mem_we_i,
	output logic                        stall_o
);

	logic rs_hit;
	logic rt_hit;

	// producers in write back are covered by the register file bypass
	assign rs_hit = (rs_i != '0) &&
		((ex_we_i && rs_i == ex_dst_i) || (mem_we_i && rs_i == mem_dst_i));

	assign rt_hit = uses_rt_i && (rt_i != '0) &&
		((ex_we_i && rt_i == ex_dst_i) || (mem_we_i && rt_i == mem_dst_i));

	assign stall_o = rs_hit || rt_hit;

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage (
	input  logic                             clk_i,
	input  logic                             rst_n_i,
	input  logic                             bubble_i,
	input  logic [pipe_pkg::EX_CTRL_W-1:0]   ex_ctrl_i,
	input  logic [pipe_pkg::MEM_CTRL_W-1:0]  mem_ctrl_i,
	input  logic [pipe_pkg::WB_CTRL_W-1:0]   wb_ctrl_i,
	input  logic [isa_pkg::WORD_W-1:0]       rda_i,
	input  logic [isa_pkg::WORD_W-1:0]       rdb_i,
	input  logic [isa_pkg::WORD_W-1:0]       imm_i,
	input  logic [isa_pkg::REG_AW-1:0]       rt_i,
	input  logic [isa_pkg::REG_AW-1:0]       rd_i,
	output logic [isa_pkg::WORD_W-1:0]       exmem_alu_o,
	output logic [isa_pkg::WORD_W-1:0]       exmem_store_o,
	output logic [isa_pkg::REG_AW-1:0]       exmem_dst_o,
	output logic [pipe_pkg::MEM_CTRL_W-1:0]  exmem_mem_ctrl_o,
	output logic [pipe_pkg::WB_CTRL_W-1:0]   exmem_wb_ctrl_o,
	output logic [isa_pkg::REG_AW-1:0]       ex_dst_o,
	output logic                             ex_we_o
);

	logic [pipe_pkg::EX_CTRL_W-1:0]  idex_ex;
	logic [pipe_pkg::MEM_CTRL_W-1:0] idex_mem;
	logic [pipe_pkg::WB_CTRL_W-1:0]  idex_wb;
	logic [isa_pkg::WORD_W-1:0]      idex_a;
	logic [isa_pkg::WORD_W-1:0]      idex_b;
	logic [isa_pkg::WORD_W-1:0]      idex_imm;
	logic [isa_pkg::REG_AW-1:0]      idex_rt;
	logic [isa_pkg::REG_AW-1:0]      idex_rd;
	logic [isa_pkg::ALU_W-1:0]       alu_op;
	logic [isa_pkg::WORD_W-1:0]      op_b;
	logic [isa_pkg::WORD_W-1:0]      alu_res;

	// bubble clears every control bit, payload may load freely
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			idex_ex  <= '0;
			idex_mem <= '0;
			idex_wb  <= '0;
		end
		else
		begin
			idex_ex  <= bubble_i ? '0 : ex_ctrl_i;
			idex_mem <= bubble_i ? '0 : mem_ctrl_i;
			idex_wb  <= bubble_i ? '0 : wb_ctrl_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		idex_a   <= rda_i;
		idex_b   <= rdb_i;
		idex_imm <= imm_i;
		idex_rt  <= rt_i;
		idex_rd  <= rd_i;
	end

	assign alu_op   = idex_ex[pipe_pkg::EX_ALU_LSB +: isa_pkg::ALU_W];
	assign op_b     = idex_ex[pipe_pkg::EX_SRC_BIT] ? idex_imm : idex_b;
	assign ex_dst_o = idex_ex[pipe_pkg::EX_DST_BIT] ? idex_rd : idex_rt;
	assign ex_we_o  = idex_wb[pipe_pkg::WB_WE_BIT];

	always_comb
	begin
		case (alu_op)
			isa_pkg::ALU_ADD: alu_res = idex_a + op_b;
			isa_pkg::ALU_SUB: alu_res = idex_a - op_b;
			// only the low word of the product is kept
			isa_pkg::ALU_MUL: alu_res = idex_a * op_b;
			isa_pkg::ALU_AND: alu_res = idex_a & op_b;
			isa_pkg::ALU_OR:  alu_res = idex_a | op_b;
			default:          alu_res = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			exmem_mem_ctrl_o <= '0;
			exmem_wb_ctrl_o  <= '0;
		end
		else
		begin
			exmem_mem_ctrl_o <= idex_mem;
			exmem_wb_ctrl_o  <= idex_wb;
		end
	end

	always_ff @(posedge clk_i)
	begin
		exmem_alu_o   <= alu_res;
		exmem_store_o <= idex_b;
		exmem_dst_o   <= ex_dst_o;
	end

endmodule

// ==== rtl/mem_stage.sv ====
module mem_stage (
	input  logic                             clk_i,
	input  logic                             rst_n_i,
	input  logic [isa_pkg::WORD_W-1:0]       alu_i,
	input  logic [isa_pkg::WORD_W-1:0]       store_i,
	input  logic [isa_pkg::REG_AW-1:0]       dst_i,
	input  logic [pipe_pkg::MEM_CTRL_W-1:0]  mem_ctrl_i,
	input  logic [pipe_pkg::WB_CTRL_W-1:0]   wb_ctrl_i,
	output logic                             wb_we_o,
	output logic [isa_pkg::REG_AW-1:0]       wb_addr_o,
	output logic [isa_pkg::WORD_W-1:0]       wb_data_o
);

	logic [isa_pkg::WORD_W-1:0]   dmem [pipe_pkg::DMEM_DEPTH];
	logic [pipe_pkg::DMEM_AW-1:0] addr;
	logic [isa_pkg::WORD_W-1:0]   load_data;
	logic                         cs;

	// word address taken from the low bits of the ALU sum
	assign addr      = alu_i[pipe_pkg::DMEM_AW-1:0];
	assign cs        = mem_ctrl_i[pipe_pkg::MEM_CS_BIT];
	assign load_data = cs ? dmem[addr] : '0;

	always_ff @(posedge clk_i)
	begin
		if (cs && mem_ctrl_i[pipe_pkg::MEM_WE_BIT])
			dmem[addr] <= store_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			wb_we_o <= 1'b0;
		else
			wb_we_o <= wb_ctrl_i[pipe_pkg::WB_WE_BIT];
	end

	always_ff @(posedge clk_i)
	begin
		wb_addr_o <= dst_i;
		wb_data_o <= wb_ctrl_i[pipe_pkg::WB_ALU_BIT] ? alu_i : load_data;
	end

endmodule

// ==== rtl/cpu_top.sv ====
module cpu_top (
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic [isa_pkg::WORD_W-1:0]   imem_data_i,
	output logic [pipe_pkg::PC_W-1:0]    imem_addr_o,
	output logic                         wb_we_o,
	output logic [isa_pkg::REG_AW-1:0]   wb_addr_o,
	output logic [isa_pkg::WORD_W-1:0]   wb_data_o
);

	isa_pkg::instr_u                 ifid_instr;
	logic [pipe_pkg::PC_W-1:0]       ifid_pc_plus1;
	logic                            ifid_valid;
	logic [isa_pkg::OPCODE_W-1:0]    op;
	logic [isa_pkg::FUNC_W-1:0]      func;
	logic [isa_pkg::REG_AW-1:0]      rs;
	logic [isa_pkg::REG_AW-1:0]      rt;
	logic [isa_pkg::REG_AW-1:0]      rd;
	logic [isa_pkg::WORD_W-1:0]      rda;
	logic [isa_pkg::WORD_W-1:0]      rdb;
	logic [isa_pkg::WORD_W-1:0]      imm_ext;
	logic                            is_equal;
	logic [pipe_pkg::PC_W-1:0]       jump_target;
	logic [pipe_pkg::PC_W-1:0]       branch_target;
	logic [pipe_pkg::PC_SEL_W-1:0]   ctrl_pc_sel;
	logic [pipe_pkg::PC_SEL_W-1:0]   pc_sel;
	logic [pipe_pkg::EX_CTRL_W-1:0]  ex_ctrl;
	logic [pipe_pkg::MEM_CTRL_W-1:0] mem_ctrl;
	logic [pipe_pkg::WB_CTRL_W-1:0]  wb_ctrl;
	logic                            uses_rt;
	logic                            stall;
	logic                            bubble;
	logic [isa_pkg::REG_AW-1:0]      ex_dst;
	logic                            ex_we;
	logic [isa_pkg::WORD_W-1:0]      exmem_alu;
	logic [isa_pkg::WORD_W-1:0]      exmem_store;
	logic [isa_pkg::REG_AW-1:0]      exmem_dst;
	logic [pipe_pkg::MEM_CTRL_W-1:0] exmem_mem_ctrl;
	logic [pipe_pkg::WB_CTRL_W-1:0]  exmem_wb_ctrl;

	// decode field split
	assign op   = ifid_instr.r_fmt.opcode;
	assign func = ifid_instr.r_fmt.func;
	assign rs   = ifid_instr.r_fmt.rs;
	assign rt   = ifid_instr.r_fmt.rt;
	assign rd   = ifid_instr.r_fmt.rd;

	assign imm_ext       = {{(isa_pkg::WORD_W - isa_pkg::IMM_W){ifid_instr.i_fmt.imm[isa_pkg::IMM_W-1]}},
		ifid_instr.i_fmt.imm};
	assign is_equal      = (rda == rdb);
	assign jump_target   = ifid_instr.j_fmt.target[pipe_pkg::PC_W-1:0];
	assign branch_target = ifid_pc_plus1 + imm_ext[pipe_pkg::PC_W-1:0];

	// rt is a source for register-operand ALU ops, beq and sw
	assign uses_rt = !ex_ctrl[pipe_pkg::EX_SRC_BIT] || mem_ctrl[pipe_pkg::MEM_WE_BIT];

	// hold the decoded redirect back until the operands are ready
	assign pc_sel = stall ? pipe_pkg::PC_SEL_SEQ : ctrl_pc_sel;
	assign bubble = stall || !ifid_valid;

	fetch_unit u_fetch (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.stall_i         (stall),
		.pc_sel_i        (pc_sel),
		.jump_target_i   (jump_target),
		.branch_target_i (branch_target),
		.imem_data_i     (imem_data_i),
		.imem_addr_o     (imem_addr_o),
		.ifid_instr_o    (ifid_instr),
		.ifid_pc_plus1_o (ifid_pc_plus1),
		.ifid_valid_o    (ifid_valid)
	);

	general_control u_ctrl (
		.op_i       (op),
		.func_i     (func),
		.is_equal_i (is_equal),
		.pc_sel_o   (ctrl_pc_sel),
		.ex_ctrl_o  (ex_ctrl),
		.mem_ctrl_o (mem_ctrl),
		.wb_ctrl_o  (wb_ctrl)
	);

	reg_file u_rf (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.ra_i    (rs),
		.rb_i    (rt),
		.wa_i    (wb_addr_o),
		.wd_i    (wb_data_o),
		.we_i    (wb_we_o),
		.rda_o   (rda),
		.rdb_o   (rdb)
	);

	hazard_unit u_hazard (
		.rs_i      (rs),
		.rt_i      (rt),
		.uses_rt_i (uses_rt),
		.ex_dst_i  (ex_dst),
		.ex_we_i   (ex_we),
		.mem_dst_i (exmem_dst),
		.mem_we_i  (exmem_wb_ctrl[pipe_pkg::WB_WE_BIT]),
		.stall_o   (stall)
	);

	execute_stage u_ex (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.bubble_i         (bubble),
		.ex_ctrl_i        (ex_ctrl),
		.mem_ctrl_i       (mem_ctrl),
		.wb_ctrl_i        (wb_ctrl),
		.rda_i            (rda),
		.rdb_i            (rdb),
		.imm_i            (imm_ext),
		.rt_i             (rt),
		.rd_i             (rd),
		.exmem_alu_o      (exmem_alu),
		.exmem_store_o    (exmem_store),
		.exmem_dst_o      (exmem_dst),
		.exmem_mem_ctrl_o (exmem_mem_ctrl),
		.exmem_wb_ctrl_o  (exmem_wb_ctrl),
		.ex_dst_o         (ex_dst),
		.ex_we_o          (ex_we)
	);

	mem_stage u_mem (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.alu_i      (exmem_alu),
		.store_i    (exmem_store),
		.dst_i      (exmem_dst),
		.mem_ctrl_i (exmem_mem_ctrl),
		.wb_ctrl_i  (exmem_wb_ctrl),
		.wb_we_o    (wb_we_o),
		.wb_addr_o  (wb_addr_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

// ==== tb/cpu_tb.sv ====
module cpu_tb;

	logic                                  clk = 1'b0;
	logic                                  rst_n = 1'b0;
	logic [pipe_pkg::PC_W-1:0]             imem_addr;
	logic [isa_pkg::WORD_W-1:0]            imem_data;
	logic                                  wb_we;
	logic [isa_pkg::REG_AW-1:0]            wb_addr;
	logic [isa_pkg::WORD_W-1:0]            wb_data;

	logic [isa_pkg::WORD_W-1:0]            imem [pipe_pkg::DMEM_DEPTH];
	logic [isa_pkg::WORD_W-1:0]            m_regs [isa_pkg::NUM_REGS];
	logic [isa_pkg::WORD_W-1:0]            m_mem [pipe_pkg::DMEM_DEPTH];

	// expected register writes in program order
	logic [isa_pkg::REG_AW-1:0]            exp_addr [256];
	logic [isa_pkg::WORD_W-1:0]            exp_data [256];
	int                                    exp_count = 0;
	int                                    rd_ptr = 0;
	logic                                  head_valid;
	logic [isa_pkg::REG_AW-1:0]            head_addr;
	logic [isa_pkg::WORD_W-1:0]            head_data;

	int                                    mismatch_errs = 0;
	int                                    extra_errs = 0;
	int                                    other_errs = 0;
	integer                                seed = 32'h5c161736;
	int                                    cycles;

	always #50 clk = ~clk;

	// instruction memory answers in the same cycle
	assign imem_data = imem[imem_addr];

	cpu_top u_dut (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.imem_data_i (imem_data),
		.imem_addr_o (imem_addr),
		.wb_we_o     (wb_we),
		.wb_addr_o   (wb_addr),
		.wb_data_o   (wb_data)
	);

	assign head_valid = (rd_ptr < exp_count);
	assign head_addr  = exp_addr[rd_ptr[7:0]];
	assign head_data  = exp_data[rd_ptr[7:0]];

	// write-back outputs change on the rising edge, so check on the falling one
	assert property (@(negedge clk) disable iff (!rst_n) wb_we |-> head_valid)
		else
		begin
			$display("unexpected write to r%0d after all expected writes were seen", wb_addr);
			extra_errs = extra_errs + 1;
		end

	assert property (@(negedge clk) disable iff (!rst_n)
		(wb_we && head_valid) |-> wb_addr == head_addr)
		else
		begin
			$display("mismatch wb_addr_o: got %h expected %h", wb_addr, head_addr);
			mismatch_errs = mismatch_errs + 1;
		end

	assert property (@(negedge clk) disable iff (!rst_n)
		(wb_we && head_valid) |-> wb_data == head_data)
		else
		begin
			$display("mismatch wb_data_o: got %h expected %h", wb_data, head_data);
			mismatch_errs = mismatch_errs + 1;
		end

	always @(posedge clk)
	begin
		if (rst_n && wb_we && head_valid)
			rd_ptr <= rd_ptr + 1;
	end

	function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [5:0] func);
		isa_pkg::instr_u w;
		w.r_fmt.opcode = isa_pkg::RTYPE_OP;
		w.r_fmt.rs     = rs;
		w.r_fmt.rt     = rt;
		w.r_fmt.rd     = rd;
		w.r_fmt.shamt  = '0;
		w.r_fmt.func   = func;
		return w;
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		isa_pkg::instr_u w;
		w.i_fmt.opcode = op;
		w.i_fmt.rs     = rs;
		w.i_fmt.rt     = rt;
		w.i_fmt.imm    = imm;
		return w;
	endfunction

	function automatic logic [31:0] enc_j(input logic [25:0] target);
		isa_pkg::instr_u w;
		w.j_fmt.opcode = isa_pkg::J_OP;
		w.j_fmt.target = target;
		return w;
	endfunction

	task automatic load_program();
		logic [15:0] rnd_a;
		logic [15:0] rnd_b;
		rnd_a = $random(seed);
		rnd_b = $random(seed);
		// unused words hold an unknown opcode tagged with their address
		for (int i = 0; i < pipe_pkg::DMEM_DEPTH; i++)
			imem[i] = {6'b111111, 18'h0, i[7:0]};
		imem[0]  = enc_i(isa_pkg::ADDI_OP, 5'd1, 5'd0, rnd_a);
		imem[1]  = enc_i(isa_pkg::ADDI_OP, 5'd2, 5'd0, rnd_b);
		imem[2]  = enc_i(isa_pkg::ADDI_OP, 5'd3, 5'd0, 16'hfffb);
		imem[3]  = enc_i(isa_pkg::ADDI_OP, 5'd4, 5'd3, 16'hfed4);
		imem[4]  = enc_r(5'd5, 5'd1, 5'd2, isa_pkg::ADD_FUNC);
		imem[5]  = enc_r(5'd6, 5'd5, 5'd1, isa_pkg::SUB_FUNC);
		imem[6]  = enc_r(5'd7, 5'd1, 5'd4, isa_pkg::MUL_FUNC);
		imem[7]  = enc_r(5'd8, 5'd6, 5'd2, isa_pkg::AND_FUNC);
		imem[8]  = enc_r(5'd9, 5'd7, 5'd3, isa_pkg::OR_FUNC);
		imem[9]  = enc_r(5'd10, 5'd7, 5'd7, isa_pkg::MUL_FUNC);
		// base address for the loads and stores
		imem[10] = enc_i(isa_pkg::ADDI_OP, 5'd11, 5'd0, 16'd20);
		imem[11] = enc_i(isa_pkg::SW_OP, 5'd5, 5'd11, 16'd0);
		imem[12] = enc_i(isa_pkg::SW_OP, 5'd9, 5'd11, 16'd3);
		imem[13] = enc_i(isa_pkg::LW_OP, 5'd12, 5'd11, 16'd0);
		imem[14] = enc_r(5'd13, 5'd12, 5'd1, isa_pkg::ADD_FUNC);
		imem[15] = enc_i(isa_pkg::LW_OP, 5'd14, 5'd11, 16'd3);
		imem[16] = enc_i(isa_pkg::LW_OP, 5'd15, 5'd11, 16'd0);
		imem[17] = enc_r(5'd16, 5'd14, 5'd15, isa_pkg::ADD_FUNC);
		// unknown function code, then a store lookalike with an unknown opcode
		imem[18] = enc_r(5'd17, 5'd1, 5'd2, 6'b111110);
		imem[19] = enc_i(6'b101111, 5'd1, 5'd11, 16'd0);
		imem[20] = enc_i(isa_pkg::LW_OP, 5'd18, 5'd11, 16'd0);
		imem[21] = enc_i(isa_pkg::BEQ_OP, 5'd5, 5'd18, 16'd2);
		imem[22] = enc_i(isa_pkg::ADDI_OP, 5'd19, 5'd0, 16'd111);
		imem[23] = enc_i(isa_pkg::ADDI_OP, 5'd19, 5'd0, 16'd222);
		imem[24] = enc_i(isa_pkg::BEQ_OP, 5'd4, 5'd3, 16'd1);
		imem[25] = enc_i(isa_pkg::ADDI_OP, 5'd20, 5'd0, 16'd7);
		imem[26] = enc_j(26'd29);
		imem[27] = enc_i(isa_pkg::ADDI_OP, 5'd21, 5'd0, 16'd1);
		imem[28] = enc_i(isa_pkg::ADDI_OP, 5'd21, 5'd0, 16'd2);
		imem[29] = enc_r(5'd22, 5'd20, 5'd10, isa_pkg::OR_FUNC);
		imem[30] = enc_j(26'd30);
	endtask

	task automatic record_write(input logic [4:0] addr, input logic [31:0] data);
		if (addr != '0)
			m_regs[addr] = data;
		exp_addr[exp_count[7:0]] = addr;
		exp_data[exp_count[7:0]] = data;
		exp_count = exp_count + 1;
	endtask

	// sequential instruction-set model, one instruction per step
	task automatic run_model();
		isa_pkg::instr_u w;
		logic [7:0]      pc;
		logic [7:0]      next_pc;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     sext;
		logic            done;
		int              steps;
		for (int i = 0; i < isa_pkg::NUM_REGS; i++)
			m_regs[i] = '0;
		for (int i = 0; i < pipe_pkg::DMEM_DEPTH; i++)
			m_mem[i] = '0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 500)
		begin
			w = imem[pc];
			a = m_regs[w.r_fmt.rs];
			b = m_regs[w.r_fmt.rt];
			sext = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
			next_pc = pc + 8'd1;
			case (w.r_fmt.opcode)
				isa_pkg::RTYPE_OP:
				begin
					case (w.r_fmt.func)
						isa_pkg::ADD_FUNC: record_write(w.r_fmt.rd, a + b);
						isa_pkg::SUB_FUNC: record_write(w.r_fmt.rd, a - b);
						isa_pkg::MUL_FUNC: record_write(w.r_fmt.rd, a * b);
						isa_pkg::AND_FUNC: record_write(w.r_fmt.rd, a & b);
						isa_pkg::OR_FUNC:  record_write(w.r_fmt.rd, a | b);
						default:           ;
					endcase
				end
				isa_pkg::ADDI_OP: record_write(w.i_fmt.rt, a + sext);
				isa_pkg::LW_OP:   record_write(w.i_fmt.rt, m_mem[(a + sext) & 32'hff]);
				isa_pkg::SW_OP:   m_mem[(a + sext) & 32'hff] = b;
				isa_pkg::BEQ_OP:
				begin
					if (a == b)
						next_pc = pc + 8'd1 + sext[7:0];
				end
				isa_pkg::J_OP:
				begin
					next_pc = w.j_fmt.target[7:0];
					if (next_pc == pc)
						done = 1'b1;
				end
				default: ;
			endcase
			pc = next_pc;
			steps = steps + 1;
		end
		if (!done)
		begin
			$display("reference model never reached the final self-loop jump");
			other_errs = other_errs + 1;
		end
	endtask

	initial
	begin
		load_program();
		run_model();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		cycles = 0;
		while (rd_ptr < exp_count && cycles < 2000)
		begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		if (rd_ptr < exp_count)
		begin
			$display("timeout: only %0d of %0d register writes seen", rd_ptr, exp_count);
			other_errs = other_errs + 1;
		end

		// core now spins on its self-loop, any further write is extra
		cycles = 0;
		while (cycles < 20)
		begin
			@(posedge clk);
			cycles = cycles + 1;
		end

		$display("errors: %0d mismatches, %0d extra writes, %0d other", mismatch_errs,
			extra_errs, other_errs);
		if (mismatch_errs == 0 && extra_errs == 0 && other_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== build.f ====
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/general_control.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/cpu_top.sv
tb/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f build.f -o cpu_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" sim.log; then
	exit 0
fi
exit 1
